// File: source/raster_pkg.sv
package raster_pkg;

    // --------------------
    // queue and address constants

    localparam int queue_depth = 8; // fragments that may wait for their depth word

    // --------------------
    // vector types

    typedef logic [25:0] pixel_addr_t; // word address in pixel memory
    typedef logic [23:0] color_t; // packed rgb
    typedef logic [31:0] depth_t; // unsigned, smaller is nearer
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0] byte_enable_t;

    // occupancy runs from 0 up to and including queue_depth
    typedef logic [$clog2(queue_depth + 1) - 1:0] queue_level_t;

    // slot index, wraps on its own since queue_depth is a power of two
    typedef logic [$clog2(queue_depth) - 1:0] queue_ptr_t;

    localparam pixel_addr_t depth_offset = 26'd4; // depth word sits this far past the pixel
    localparam byte_enable_t read_byte_enable = 4'b1111;

    // --------------------
    // read issuer states

    typedef enum logic {
        fetch_idle,
        fetch_issue
    } fetch_state_t;

endpackage

// File: source/depth_fetch_queue.sv
`timescale 1ns/1ns

module depth_fetch_queue (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write,
    input  logic                     read,
    input  raster_pkg::pixel_addr_t  in_addr,
    input  raster_pkg::color_t       in_color,
    input  raster_pkg::depth_t       in_depth,
    input  logic                     in_done,
    output raster_pkg::pixel_addr_t  out_addr,
    output raster_pkg::color_t       out_color,
    output raster_pkg::depth_t       out_depth,
    output logic                     out_done,
    output logic                     full,
    output logic                     empty,
    output raster_pkg::queue_level_t level
);
    import raster_pkg::*;

    pixel_addr_t addr_mem [queue_depth];
    color_t color_mem [queue_depth];
    depth_t depth_mem [queue_depth];
    logic done_mem [queue_depth];

    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    logic do_write;
    logic do_read;

    assign full = (level == queue_level_t'(queue_depth));
    assign empty = (level == '0);
    assign do_write = write && !full; // a push into a full queue is dropped
    assign do_read = read && !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            addr_mem[wr_ptr] <= in_addr;
            color_mem[wr_ptr] <= in_color;
            depth_mem[wr_ptr] <= in_depth;
            done_mem[wr_ptr] <= in_done;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level; // push and pop together leave the count alone
            endcase
        end
    end

    // oldest entry is always visible at the head
    assign out_addr = addr_mem[rd_ptr];
    assign out_color = color_mem[rd_ptr];
    assign out_depth = depth_mem[rd_ptr];
    assign out_done = done_mem[rd_ptr];

endmodule

// File: source/depth_fetch.sv
`timescale 1ns/1ns

module depth_fetch (
    input  logic                     clock,
    input  logic                     reset,

    // fragment input
    input  logic                     input_valid,
    input  raster_pkg::pixel_addr_t  addr_in,
    input  raster_pkg::color_t       color_in,
    input  raster_pkg::depth_t       depth_in,
    input  logic                     done_in,
    output logic                     stall_out,

    // memory bus
    output raster_pkg::pixel_addr_t  master_address,
    output logic                     master_read,
    output raster_pkg::byte_enable_t master_byteenable,
    input  raster_pkg::bus_data_t    master_readdata,
    input  logic                     master_readdatavalid,
    input  logic                     master_waitrequest,

    // to depth test
    output logic                     fetch_valid,
    output raster_pkg::pixel_addr_t  fetch_addr,
    output raster_pkg::color_t       fetch_color,
    output raster_pkg::depth_t       fetch_new_depth,
    output raster_pkg::depth_t       fetch_old_depth,
    output logic                     fetch_done
);
    import raster_pkg::*;

    fetch_state_t state;
    logic started;
    logic accept;

    logic queue_full;
    logic queue_empty;
    queue_level_t queue_level;
    pixel_addr_t head_addr;
    color_t head_color;
    depth_t head_depth;
    logic head_done;

    // --------------------
    // fragment intake

    // input is held off for the first cycle out of reset, while a read waits
    // at the bus, and whenever every queue slot is taken
    assign stall_out = !started || (state != fetch_idle) || queue_full;
    assign accept = input_valid && !stall_out;

    depth_fetch_queue queue0 (
        .clock     (clock),
        .reset     (reset),
        .write     (accept),
        .read      (master_readdatavalid), // every returned word retires the oldest fragment
        .in_addr   (addr_in),
        .in_color  (color_in),
        .in_depth  (depth_in),
        .in_done   (done_in),
        .out_addr  (head_addr),
        .out_color (head_color),
        .out_depth (head_depth),
        .out_done  (head_done),
        .full      (queue_full),
        .empty     (queue_empty),
        .level     (queue_level)
    );

    // --------------------
    // read issue

    assign master_byteenable = read_byte_enable;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= fetch_idle;
            started <= 1'b0;
            master_read <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                fetch_idle: begin
                    if (accept) begin
                        state <= fetch_issue;
                        master_read <= 1'b1;
                    end
                end
                fetch_issue: begin
                    if (!master_waitrequest) begin // read taken by memory
                        state <= fetch_idle;
                        master_read <= 1'b0;
                    end
                end
                default: begin
                    state <= fetch_idle;
                    master_read <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            master_address <= addr_in + depth_offset; // stays put until the read is taken
        end
    end

    // --------------------
    // read return

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= master_readdatavalid && !queue_empty;
        end
    end

    always_ff @(posedge clock) begin
        if (master_readdatavalid) begin
            fetch_addr <= head_addr;
            fetch_color <= head_color;
            fetch_new_depth <= head_depth;
            fetch_old_depth <= master_readdata; // stored depth from the buffer
            fetch_done <= head_done;
        end
    end

endmodule

// File: source/depth_test.sv
`timescale 1ns/1ns

module depth_test (
    input  logic                    clock,
    input  logic                    reset,

    // from fetch
    input  logic                    fetch_valid,
    input  raster_pkg::pixel_addr_t fetch_addr,
    input  raster_pkg::color_t      fetch_color,
    input  raster_pkg::depth_t      fetch_new_depth,
    input  raster_pkg::depth_t      fetch_old_depth,
    input  logic                    fetch_done,

    // pixel write
    output logic                    pixel_valid,
    output raster_pkg::pixel_addr_t pixel_addr,
    output raster_pkg::color_t      pixel_color,
    output raster_pkg::depth_t      pixel_depth,
    output logic                    done_out
);

    logic nearer;

    assign nearer = fetch_new_depth < fetch_old_depth; // ties lose

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pixel_valid <= 1'b0;
            done_out <= 1'b0;
        end else begin
            pixel_valid <= fetch_valid && nearer;
            done_out <= fetch_valid && fetch_done; // done goes out whether the test passes or not
        end
    end

    // write payload follows every fragment, pixel_valid says whether it counts
    always_ff @(posedge clock) begin
        if (fetch_valid) begin
            pixel_addr <= fetch_addr;
            pixel_color <= fetch_color;
            pixel_depth <= fetch_new_depth;
        end
    end

endmodule

// File: source/depth_stage.sv
`timescale 1ns/1ns

module depth_stage (
    input  logic                     clock,
    input  logic                     reset,

    // fragment input
    input  logic                     input_valid,
    input  raster_pkg::pixel_addr_t  addr_in,
    input  raster_pkg::color_t       color_in,
    input  raster_pkg::depth_t       depth_in,
    input  logic                     done_in,
    output logic                     stall_out,

    // memory bus
    output raster_pkg::pixel_addr_t  master_address,
    output logic                     master_read,
    output raster_pkg::byte_enable_t master_byteenable,
    input  raster_pkg::bus_data_t    master_readdata,
    input  logic                     master_readdatavalid,
    input  logic                     master_waitrequest,

    // pixel write
    output logic                     pixel_valid,
    output raster_pkg::pixel_addr_t  pixel_addr,
    output raster_pkg::color_t       pixel_color,
    output raster_pkg::depth_t       pixel_depth,
    output logic                     done_out
);
    import raster_pkg::*;

    logic fetch_valid;
    pixel_addr_t fetch_addr;
    color_t fetch_color;
    depth_t fetch_new_depth;
    depth_t fetch_old_depth;
    logic fetch_done;

    depth_fetch fetch0 (
        .clock                (clock),
        .reset                (reset),
        .input_valid          (input_valid),
        .addr_in              (addr_in),
        .color_in             (color_in),
        .depth_in             (depth_in),
        .done_in              (done_in),
        .stall_out            (stall_out),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_byteenable    (master_byteenable),
        .master_readdata      (master_readdata),
        .master_readdatavalid (master_readdatavalid),
        .master_waitrequest   (master_waitrequest),
        .fetch_valid          (fetch_valid),
        .fetch_addr           (fetch_addr),
        .fetch_color          (fetch_color),
        .fetch_new_depth      (fetch_new_depth),
        .fetch_old_depth      (fetch_old_depth),
        .fetch_done           (fetch_done)
    );

    depth_test test0 (
        .clock           (clock),
        .reset           (reset),
        .fetch_valid     (fetch_valid),
        .fetch_addr      (fetch_addr),
        .fetch_color     (fetch_color),
        .fetch_new_depth (fetch_new_depth),
        .fetch_old_depth (fetch_old_depth),
        .fetch_done      (fetch_done),
        .pixel_valid     (pixel_valid),
        .pixel_addr      (pixel_addr),
        .pixel_color     (pixel_color),
        .pixel_depth     (pixel_depth),
        .done_out        (done_out)
    );

endmodule

// File: dv/depth_stage_props.sv
`timescale 1ns/1ns

module depth_stage_props (
    input logic                     clock,
    input logic                     reset,
    input logic                     master_read,
    input raster_pkg::pixel_addr_t  master_address,
    input logic                     master_waitrequest,
    input logic                     master_readdatavalid,
    input logic                     queue_empty,
    input raster_pkg::queue_level_t queue_level,
    input logic                     accept
);

    // a read held off by waitrequest keeps its strobe and address
    read_held: assert property (@(posedge clock) disable iff (!reset)
        master_read && master_waitrequest |=> master_read && $stable(master_address))
        else $error("read strobe or address changed while waitrequest held it");

    return_with_entry: assert property (@(posedge clock) disable iff (!reset)
        master_readdatavalid |-> !queue_empty) // every word needs a fragment to pair with
        else $error("readdatavalid arrived with the fragment queue empty");

    // a fragment taken into a full queue would be dropped and leave the count short
    accept_stored: assert property (@(posedge clock) disable iff (!reset)
        accept && !master_readdatavalid |=> queue_level == $past(queue_level) + 1'b1)
        else $error("accepted fragment was not stored in the queue");

endmodule

bind depth_fetch depth_stage_props props0 (.*);

// File: dv/depth_stage_tb.sv
`timescale 1ns/1ns

module depth_stage_tb;
    import raster_pkg::*;

    localparam int total_fragments = 256; // 1 + 3 + 200 + 40 + 12 over the five tests

    typedef struct packed {
        logic pass;
        pixel_addr_t addr;
        color_t color;
        depth_t depth;
        logic done;
    } result_t;

    logic clock;
    logic reset;
    logic input_valid;
    pixel_addr_t addr_in;
    color_t color_in;
    depth_t depth_in;
    logic done_in;
    logic stall_out;
    pixel_addr_t master_address;
    logic master_read;
    byte_enable_t master_byteenable;
    bus_data_t master_readdata;
    logic master_readdatavalid;
    logic master_waitrequest;
    logic pixel_valid;
    pixel_addr_t pixel_addr;
    color_t pixel_color;
    depth_t pixel_depth;
    logic done_out;

    result_t expected_q[$];
    pixel_addr_t read_addr_q[$];
    int read_due_q[$];
    pixel_addr_t forced_addr[4];
    depth_t forced_value[4];
    int forced_count;
    int lat_min;
    int lat_max;
    int wait_pct;
    int cycle_count;
    int max_outstanding;
    int stall_cycles;
    int accepted_count;
    int result_count;
    int error_count;
    int check_count;
    int test_count;
    int failed_tests;
    logic [1:0] return_hist;

    depth_stage dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // --------------------
    // reference

    // fixed hash of the whole address stands in for the depth buffer contents
    function automatic depth_t depth_at(pixel_addr_t a);
        return ({6'd0, a} * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic depth_t stored_depth(pixel_addr_t a);
        for (int i = 0; i < forced_count; i++) begin
            if (forced_addr[i] == a) begin
                return forced_value[i];
            end
        end
        return depth_at(a);
    endfunction

    function automatic result_t expect_result(pixel_addr_t a, color_t c, depth_t d, logic done);
        result_t r;
        r.pass = d < stored_depth(a + depth_offset); // strictly nearer wins
        r.addr = a;
        r.color = c;
        r.depth = d;
        r.done = done;
        return r;
    endfunction

    // --------------------
    // compare tasks

    task automatic check_addr(string name, pixel_addr_t got, pixel_addr_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_color(string name, color_t got, color_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_depth(string name, depth_t got, depth_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_enable(string name, byte_enable_t got, byte_enable_t want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_flag(string name, logic got, logic want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic report_error(string what);
        error_count++;
        $display("[ERROR] %0t %s", $time, what);
    endtask

    // --------------------
    // stimulus helpers

    task automatic send_fragment(pixel_addr_t a, color_t c, depth_t d, logic done);
        logic taken;
        taken = 1'b0;
        input_valid = 1'b1;
        addr_in = a;
        color_in = c;
        depth_in = d;
        done_in = done;
        while (!taken) begin
            @(negedge clock);
            taken = !stall_out; // taken on the coming edge
            if (!taken && !master_read) begin // a stall with no read pending means a full queue
                stall_cycles++;
            end
        end
        @(posedge clock);
        expected_q.push_back(expect_result(a, c, d, done));
        accepted_count++;
        #5;
        input_valid = 1'b0;
    endtask

    task automatic send_random(logic done);
        send_fragment(pixel_addr_t'($urandom()), color_t'($urandom()), $urandom(), done);
    endtask

    task automatic wait_results();
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (3) @(negedge clock); // a stray pulse would be caught here
        @(posedge clock);
        #5;
    endtask

    task automatic end_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    // --------------------
    // memory model

    initial begin
        master_waitrequest = 1'b0;
        master_readdatavalid = 1'b0;
        master_readdata = '0;
        forever begin
            @(negedge clock);
            if (reset && master_read && !master_waitrequest) begin
                read_addr_q.push_back(master_address);
                read_due_q.push_back(cycle_count + $urandom_range(lat_max, lat_min));
                if (read_addr_q.size() > max_outstanding) begin
                    max_outstanding = read_addr_q.size();
                end
            end
            @(posedge clock);
            cycle_count++;
            #5;
            master_readdatavalid = 1'b0;
            if (read_due_q.size() != 0 && read_due_q[0] <= cycle_count) begin
                void'(read_due_q.pop_front());
                master_readdata = stored_depth(read_addr_q.pop_front());
                master_readdatavalid = 1'b1;
            end
            master_waitrequest = ($urandom_range(99) < wait_pct);
        end
    end

    // --------------------
    // comparer, a result shows two cycles after its word returns

    task automatic compare_result();
        result_t e;
        result_count++;
        if (expected_q.size() == 0) begin
            report_error("result came out with no accepted fragment waiting for it");
        end else begin
            e = expected_q.pop_front();
            check_flag("pixel_valid", pixel_valid, e.pass);
            if (e.pass) begin
                check_addr("pixel_addr", pixel_addr, e.addr);
                check_color("pixel_color", pixel_color, e.color);
                check_depth("pixel_depth", pixel_depth, e.depth);
            end
            check_flag("done_out", done_out, e.done);
        end
    endtask

    initial begin
        return_hist = 2'b00;
        forever begin
            @(negedge clock);
            if (return_hist[1]) begin
                compare_result();
            end else if (reset && (pixel_valid || done_out)) begin
                report_error("pixel_valid or done_out pulsed with no returned word behind it");
            end
            return_hist = {return_hist[0], master_readdatavalid};
        end
    end

    initial begin
        repeat (total_fragments * 20) @(posedge clock);
        $display("watchdog expired with %0d results still pending", expected_q.size());
        $display("FAIL: see errors above");
        $finish;
    end

    // --------------------
    // tests

    initial begin
        int errors_before;
        int accepted_before;
        int results_before;
        pixel_addr_t a;
        depth_t d;
        void'($urandom(87355));
        reset = 1'b0;
        input_valid = 1'b0;
        addr_in = '0;
        color_in = '0;
        depth_in = '0;
        done_in = 1'b0;
        forced_count = 0;
        lat_min = 1;
        lat_max = 6;
        wait_pct = 0;
        cycle_count = 0;
        max_outstanding = 0;
        stall_cycles = 0;
        accepted_count = 0;
        result_count = 0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        failed_tests = 0;

        errors_before = error_count;
        repeat (15) @(posedge clock);
        @(negedge clock);
        check_flag("stall_out", stall_out, 1'b1);
        check_flag("master_read", master_read, 1'b0);
        check_flag("pixel_valid", pixel_valid, 1'b0);
        check_flag("done_out", done_out, 1'b0);
        @(posedge clock);
        #5;
        reset = 1'b1;
        repeat (3) begin
            @(negedge clock);
            check_flag("master_read", master_read, 1'b0);
            check_flag("pixel_valid", pixel_valid, 1'b0);
            check_flag("done_out", done_out, 1'b0);
        end
        @(posedge clock);
        #5;
        a = 26'h012_3450;
        send_fragment(a, 24'h10_20_30, 32'h0000_0100, 1'b0);
        @(negedge clock);
        check_flag("master_read", master_read, 1'b1);
        check_addr("master_address", master_address, a + depth_offset);
        check_enable("master_byteenable", master_byteenable, 4'b1111);
        wait_results();
        end_test("reset and first read", errors_before);

        errors_before = error_count;
        a = 26'h000_0400;
        forced_addr[0] = a + depth_offset;
        forced_value[0] = 32'd1000;
        forced_count = 1;
        send_fragment(a, 24'haa_0001, 32'd1001, 1'b0);
        send_fragment(a, 24'haa_0002, 32'd1000, 1'b0);
        send_fragment(a, 24'haa_0003, 32'd999, 1'b0);
        wait_results();
        end_test("depth above, equal and below", errors_before);

        errors_before = error_count;
        wait_pct = 30;
        repeat (200) send_random($urandom_range(9) == 0);
        wait_results();
        end_test("ordering under latency", errors_before);

        errors_before = error_count;
        wait_pct = 0;
        lat_min = 20;
        lat_max = 30;
        stall_cycles = 0;
        max_outstanding = 0;
        accepted_before = accepted_count;
        results_before = result_count;
        repeat (40) send_random(1'b0);
        wait_results();
        if (stall_cycles == 0) begin
            report_error("stall_out never held input back on a full queue");
        end
        if (max_outstanding != queue_depth) begin
            report_error($sformatf("peak outstanding reads was %0d", max_outstanding));
        end
        if (accepted_count - accepted_before != result_count - results_before) begin
            report_error("result count differs from accepted fragment count");
        end
        end_test("back-pressure", errors_before);

        errors_before = error_count;
        wait_pct = 20;
        lat_min = 1;
        lat_max = 6;
        for (int i = 0; i < 12; i++) begin
            a = pixel_addr_t'($urandom());
            d = stored_depth(a + depth_offset);
            send_fragment(a, color_t'(i), (i % 2 == 0) ? d - 1 : d, i % 3 != 2);
        end
        wait_results();
        end_test("done flag", errors_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: depth_stage.f
source/raster_pkg.sv
source/depth_fetch_queue.sv
source/depth_fetch.sv
source/depth_test.sv
source/depth_stage.sv
dv/depth_stage_props.sv
dv/depth_stage_tb.sv

// File: Bender.yml
package:
  name: depth_stage

sources:
  - files:
      - source/raster_pkg.sv
      - source/depth_fetch_queue.sv
      - source/depth_fetch.sv
      - source/depth_test.sv
      - source/depth_stage.sv
  - target: simulation
    files:
      - dv/depth_stage_props.sv
      - dv/depth_stage_tb.sv
